// ==== hw/cdc_clear_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_clear_seq #(
  parameter int SyncStages = 2
) (
  input  wire logic src_clk_i,
  input  wire logic src_rst_ni,
  input  wire logic src_clear_i,
  input  wire logic dst_clk_i,
  input  wire logic dst_rst_ni,
  input  wire logic dst_clear_i,
  output logic      src_isolate_o,
  output logic      src_clear_o,
  output logic      src_clear_pending_o,
  output logic      dst_isolate_o,
  output logic      dst_clear_o,
  output logic      dst_clear_pending_o
);

  cdc_fifo_pkg::clear_state_e src_state_q;
  cdc_fifo_pkg::clear_state_e src_ack_q;
  cdc_fifo_pkg::clear_state_e dst_state_q;
  cdc_fifo_pkg::clear_state_e dst_ack_q;
  // phase of the other side, synchronized into the local domain
  cdc_fifo_pkg::clear_state_e dst_in_src_q [SyncStages];
  cdc_fifo_pkg::clear_state_e src_in_dst_q [SyncStages];
  cdc_fifo_pkg::clear_state_e src_remote;
  cdc_fifo_pkg::clear_state_e dst_remote;

  // one step of a side's phase machine
  // each phase is held until the local acknowledge register has caught up,
  // which gives the isolation and clear one local cycle to take effect
  // the machine only moves once the remote phase equals or leads its own
  function automatic cdc_fifo_pkg::clear_state_e next_phase(
    input cdc_fifo_pkg::clear_state_e cur,
    input cdc_fifo_pkg::clear_state_e ack,
    input cdc_fifo_pkg::clear_state_e remote,
    input logic                       req
  );
    cdc_fifo_pkg::clear_state_e nxt;
    nxt = cur;
    case (cur)
      cdc_fifo_pkg::CLR_IDLE: begin
        // a local request and a remote start merge into one sequence
        if (req || remote == cdc_fifo_pkg::CLR_ISOLATE) begin
          nxt = cdc_fifo_pkg::CLR_ISOLATE;
        end
      end
      cdc_fifo_pkg::CLR_ISOLATE: begin
        if (ack == cur && (remote == cdc_fifo_pkg::CLR_ISOLATE ||
                           remote == cdc_fifo_pkg::CLR_CLEAR)) begin
          nxt = cdc_fifo_pkg::CLR_CLEAR;
        end
      end
      cdc_fifo_pkg::CLR_CLEAR: begin
        if (ack == cur && (remote == cdc_fifo_pkg::CLR_CLEAR ||
                           remote == cdc_fifo_pkg::CLR_RELEASE)) begin
          nxt = cdc_fifo_pkg::CLR_RELEASE;
        end
      end
      default: begin
        // the remote may already be idle or even starting a new sequence
        if (ack == cur && remote != cdc_fifo_pkg::CLR_CLEAR) begin
          nxt = cdc_fifo_pkg::CLR_IDLE;
        end
      end
    endcase
    return nxt;
  endfunction

  assign src_remote = dst_in_src_q[SyncStages-1];
  assign dst_remote = src_in_dst_q[SyncStages-1];

  // source domain machine with the synchronizer for the dst phase
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      src_state_q <= cdc_fifo_pkg::CLR_IDLE;
      src_ack_q   <= cdc_fifo_pkg::CLR_IDLE;
      for (int s = 0; s < SyncStages; s++) begin
        dst_in_src_q[s] <= cdc_fifo_pkg::CLR_IDLE;
      end
    end else begin
      src_state_q     <= next_phase(src_state_q, src_ack_q, src_remote, src_clear_i);
      src_ack_q       <= src_state_q;
      dst_in_src_q[0] <= dst_state_q;
      for (int s = 1; s < SyncStages; s++) begin
        dst_in_src_q[s] <= dst_in_src_q[s-1];
      end
    end
  end

  // destination domain machine, the mirror of the one above
  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      dst_state_q <= cdc_fifo_pkg::CLR_IDLE;
      dst_ack_q   <= cdc_fifo_pkg::CLR_IDLE;
      for (int s = 0; s < SyncStages; s++) begin
        src_in_dst_q[s] <= cdc_fifo_pkg::CLR_IDLE;
      end
    end else begin
      dst_state_q     <= next_phase(dst_state_q, dst_ack_q, dst_remote, dst_clear_i);
      dst_ack_q       <= dst_state_q;
      src_in_dst_q[0] <= src_state_q;
      for (int s = 1; s < SyncStages; s++) begin
        src_in_dst_q[s] <= src_in_dst_q[s-1];
      end
    end
  end

  // isolation covers the whole sequence, from isolate through release
  assign src_isolate_o       = (src_state_q != cdc_fifo_pkg::CLR_IDLE);
  assign dst_isolate_o       = (dst_state_q != cdc_fifo_pkg::CLR_IDLE);
  assign src_clear_pending_o = src_isolate_o;
  assign dst_clear_pending_o = dst_isolate_o;

  // clear fires in the first cycle of the clear phase only
  assign src_clear_o = (src_state_q == cdc_fifo_pkg::CLR_CLEAR) &&
                       (src_ack_q != cdc_fifo_pkg::CLR_CLEAR);
  assign dst_clear_o = (dst_state_q == cdc_fifo_pkg::CLR_CLEAR) &&
                       (dst_ack_q != cdc_fifo_pkg::CLR_CLEAR);

endmodule

`default_nettype wire

// ==== hw/cdc_fifo_clearable.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_clearable #(
  parameter int LogDepth   = 3,
  parameter int SyncStages = 2
) (
  input  wire logic                src_clk_i,
  input  wire logic                src_rst_ni,
  input  wire logic                src_clear_i,
  output logic                     src_clear_pending_o,
  input  wire cdc_fifo_pkg::data_t src_data_i,
  input  wire logic                src_valid_i,
  output logic                     src_ready_o,

  input  wire logic                dst_clk_i,
  input  wire logic                dst_rst_ni,
  input  wire logic                dst_clear_i,
  output logic                     dst_clear_pending_o,
  output cdc_fifo_pkg::data_t      dst_data_o,
  output logic                     dst_valid_o,
  input  wire logic                dst_ready_i
);

  // storage array, only read in the dst domain once the write pointer says so
  cdc_fifo_pkg::data_t [2**LogDepth-1:0] store;
  logic [LogDepth:0] wptr_gray;
  logic [LogDepth:0] rptr_gray;
  logic [LogDepth:0] wptr_bin_dst;
  logic [LogDepth:0] rptr_bin_src;
  logic              src_isolate;
  logic              src_clear;
  logic              dst_isolate;
  logic              dst_clear;

  cdc_fifo_src #(
    .LogDepth (LogDepth)
  ) u_src (
    .src_clk_i   (src_clk_i),
    .src_rst_ni  (src_rst_ni),
    .src_data_i  (src_data_i),
    .src_valid_i (src_valid_i),
    .clear_i     (src_clear),
    .isolate_i   (src_isolate),
    .rptr_bin_i  (rptr_bin_src),
    .src_ready_o (src_ready_o),
    .store_o     (store),
    .wptr_gray_o (wptr_gray)
  );

  // write pointer into the destination domain
  cdc_ptr_sync #(
    .PtrWidth   (LogDepth + 1),
    .SyncStages (SyncStages)
  ) u_wptr_sync (
    .clk_i  (dst_clk_i),
    .rst_ni (dst_rst_ni),
    .gray_i (wptr_gray),
    .bin_o  (wptr_bin_dst)
  );

  // read pointer back into the source domain
  cdc_ptr_sync #(
    .PtrWidth   (LogDepth + 1),
    .SyncStages (SyncStages)
  ) u_rptr_sync (
    .clk_i  (src_clk_i),
    .rst_ni (src_rst_ni),
    .gray_i (rptr_gray),
    .bin_o  (rptr_bin_src)
  );

  cdc_fifo_dst #(
    .LogDepth (LogDepth)
  ) u_dst (
    .dst_clk_i   (dst_clk_i),
    .dst_rst_ni  (dst_rst_ni),
    .store_i     (store),
    .wptr_bin_i  (wptr_bin_dst),
    .clear_i     (dst_clear),
    .isolate_i   (dst_isolate),
    .dst_ready_i (dst_ready_i),
    .rptr_gray_o (rptr_gray),
    .dst_data_o  (dst_data_o),
    .dst_valid_o (dst_valid_o)
  );

  cdc_clear_seq #(
    .SyncStages (SyncStages)
  ) u_clear (
    .src_clk_i           (src_clk_i),
    .src_rst_ni          (src_rst_ni),
    .src_clear_i         (src_clear_i),
    .dst_clk_i           (dst_clk_i),
    .dst_rst_ni          (dst_rst_ni),
    .dst_clear_i         (dst_clear_i),
    .src_isolate_o       (src_isolate),
    .src_clear_o         (src_clear),
    .src_clear_pending_o (src_clear_pending_o),
    .dst_isolate_o       (dst_isolate),
    .dst_clear_o         (dst_clear),
    .dst_clear_pending_o (dst_clear_pending_o)
  );

endmodule

`default_nettype wire

// ==== hw/cdc_fifo_dst.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_dst #(
  parameter int LogDepth = 3
) (
  input  wire logic                                    dst_clk_i,
  input  wire logic                                    dst_rst_ni,
  input  wire cdc_fifo_pkg::data_t [2**LogDepth-1:0]   store_i,
  input  wire logic [LogDepth:0]                       wptr_bin_i,
  input  wire logic                                    clear_i,
  input  wire logic                                    isolate_i,
  input  wire logic                                    dst_ready_i,
  output logic [LogDepth:0]                            rptr_gray_o,
  output cdc_fifo_pkg::data_t                          dst_data_o,
  output logic                                         dst_valid_o
);

  typedef logic [LogDepth:0] ptr_t;

  ptr_t                rptr_q;
  ptr_t                rptr_d;
  ptr_t                rptr_gray_q;
  logic                not_empty;
  logic                spill_valid_in;
  logic                spill_ready;
  logic                spill_valid_out;
  logic                pop;
  cdc_fifo_pkg::data_t head_word;

  // equal pointers mean empty, the write pointer lags the source
  assign not_empty = (wptr_bin_i != rptr_q);

  // oldest word, the slot has been stable for at least the sync delay
  assign head_word = store_i[rptr_q[LogDepth-1:0]];

  // nothing new enters the spill while isolated
  // after the clear the synchronized write pointer may still be stale
  // for a few cycles and must not be mistaken for data
  assign spill_valid_in = not_empty && !isolate_i && !clear_i;
  assign pop            = spill_valid_in && spill_ready;

  always_comb begin
    rptr_d = rptr_q;
    if (clear_i) begin
      rptr_d = '0;
    end else if (pop) begin
      rptr_d = rptr_q + ptr_t'(1);
    end
  end

  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      rptr_q      <= '0;
      rptr_gray_q <= '0;
    end else begin
      rptr_q      <= rptr_d;
      rptr_gray_q <= rptr_d ^ (rptr_d >> 1);
    end
  end

  assign rptr_gray_o = rptr_gray_q;

  // output buffer, cuts the combinational ready path into the pointer logic
  cdc_spill_register u_spill (
    .dst_clk_i  (dst_clk_i),
    .dst_rst_ni (dst_rst_ni),
    .flush_i    (clear_i),
    .valid_i    (spill_valid_in),
    .data_i     (head_word),
    .ready_o    (spill_ready),
    .valid_o    (spill_valid_out),
    .ready_i    (dst_ready_i && !isolate_i),
    .data_o     (dst_data_o)
  );

  // the consumer sees no word during the clear sequence
  assign dst_valid_o = spill_valid_out && !isolate_i;

endmodule

`default_nettype wire

// ==== hw/cdc_fifo_pkg.sv ====
`default_nettype none

package cdc_fifo_pkg;

  // width of one payload word moved across the clock boundary
  localparam int DataWidth = 16;

  // payload word as seen on both sides of the FIFO
  typedef logic [DataWidth-1:0] data_t;

  // phase of the clear sequencer in one clock domain
  // the values form a gray cycle so the copy synchronized into the
  // other domain only ever sees one bit change per phase step
  // idle -> isolate -> clear -> release -> idle
  typedef enum logic [1:0] {
    CLR_IDLE    = 2'b00,
    CLR_ISOLATE = 2'b01,
    CLR_CLEAR   = 2'b11,
    CLR_RELEASE = 2'b10
  } clear_state_e;

endpackage

`default_nettype wire

// ==== hw/cdc_fifo_src.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_src #(
  parameter int LogDepth = 3
) (
  input  wire logic                                    src_clk_i,
  input  wire logic                                    src_rst_ni,
  input  wire cdc_fifo_pkg::data_t                     src_data_i,
  input  wire logic                                    src_valid_i,
  input  wire logic                                    clear_i,
  input  wire logic                                    isolate_i,
  input  wire logic [LogDepth:0]                       rptr_bin_i,
  output logic                                         src_ready_o,
  output cdc_fifo_pkg::data_t [2**LogDepth-1:0]        store_o,
  output logic [LogDepth:0]                            wptr_gray_o
);

  localparam int Depth = 2 ** LogDepth;

  // pointers carry one extra wrap bit above the slot address
  typedef logic [LogDepth:0] ptr_t;

  // write and read pointer differ only in the wrap bit when full
  localparam ptr_t PtrFull = ptr_t'(Depth);

  ptr_t wptr_q;
  ptr_t wptr_d;
  ptr_t wptr_gray_q;
  logic full;
  logic push;

  // the read pointer is a few cycles old, so full is pessimistic
  // and the array can never be overrun
  assign full = ((wptr_q ^ rptr_bin_i) == PtrFull);

  // while the clear sequence runs the producer sees no space
  assign src_ready_o = !full && !isolate_i;
  assign push        = src_valid_i && src_ready_o;

  // the clear pulse wins over a push, which cannot happen while isolated anyway
  always_comb begin
    wptr_d = wptr_q;
    if (clear_i) begin
      wptr_d = '0;
    end else if (push) begin
      wptr_d = wptr_q + ptr_t'(1);
    end
  end

  // the gray copy is registered so the crossing sees no glitches
  always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
    if (!src_rst_ni) begin
      wptr_q      <= '0;
      wptr_gray_q <= '0;
    end else begin
      wptr_q      <= wptr_d;
      wptr_gray_q <= wptr_d ^ (wptr_d >> 1);
    end
  end

  assign wptr_gray_o = wptr_gray_q;

  // storage array, written at the slot addressed by the low pointer bits
  // the destination side reads it only after the pointer has crossed
  always_ff @(posedge src_clk_i) begin
    if (push) begin
      store_o[wptr_q[LogDepth-1:0]] <= src_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== hw/cdc_ptr_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_ptr_sync #(
  parameter int PtrWidth   = 4,
  parameter int SyncStages = 2
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  input  wire logic [PtrWidth-1:0] gray_i,
  output logic      [PtrWidth-1:0] bin_o
);

  typedef logic [PtrWidth-1:0] ptr_t;

  ptr_t sync_q [SyncStages];
  ptr_t gray_q;

  // plain flip-flop chain, each bit is sampled independently
  // the gray code guarantees that at most one bit is in flight
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int s = 0; s < SyncStages; s++) begin
        sync_q[s] <= '0;
      end
    end else begin
      sync_q[0] <= gray_i;
      for (int s = 1; s < SyncStages; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  // only the last stage is considered settled
  assign gray_q = sync_q[SyncStages-1];

  // binary bit i is the parity of all gray bits from i upward
  always_comb begin
    for (int i = 0; i < PtrWidth; i++) begin
      bin_o[i] = ^(gray_q >> i);
    end
  end

endmodule

`default_nettype wire

// ==== hw/cdc_spill_register.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_spill_register (
  input  wire logic                dst_clk_i,
  input  wire logic                dst_rst_ni,
  input  wire logic                flush_i,
  input  wire logic                valid_i,
  input  wire cdc_fifo_pkg::data_t data_i,
  output logic                     ready_o,
  output logic                     valid_o,
  input  wire logic                ready_i,
  output cdc_fifo_pkg::data_t      data_o
);

  // slot a drives the output, slot b catches a word that arrives
  // while slot a is stalled
  logic                a_full_q;
  logic                b_full_q;
  cdc_fifo_pkg::data_t a_data_q;
  cdc_fifo_pkg::data_t b_data_q;
  logic                take_in;
  logic                take_out;

  // ready only looks at local state, so no path from ready_i
  assign ready_o = !b_full_q;
  assign valid_o = a_full_q;
  assign data_o  = a_data_q;

  assign take_in  = valid_i && ready_o;
  assign take_out = valid_o && ready_i;

  always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
    if (!dst_rst_ni) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else if (flush_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else if (take_out) begin
      // slot a refills from b first, else straight from the input
      a_full_q <= b_full_q || take_in;
      b_full_q <= 1'b0;
    end else if (take_in) begin
      a_full_q <= 1'b1;
      b_full_q <= a_full_q;
    end
  end

  // payload follows the same decisions as the fill flags
  always_ff @(posedge dst_clk_i) begin
    if (take_out) begin
      if (b_full_q) begin
        a_data_q <= b_data_q;
      end else if (take_in) begin
        a_data_q <= data_i;
      end
    end else if (take_in) begin
      if (a_full_q) begin
        b_data_q <= data_i;
      end else begin
        a_data_q <= data_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== list.f ====
hw/cdc_fifo_pkg.sv
hw/cdc_ptr_sync.sv
hw/cdc_fifo_src.sv
hw/cdc_spill_register.sv
hw/cdc_fifo_dst.sv
hw/cdc_clear_seq.sv
hw/cdc_fifo_clearable.sv
tb/cdc_fifo_assert.sv
tb/tb_cdc_fifo.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and judges the log

set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
fail_text="Regression failed"
pass_text="Regression passed"

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f list.f --top-module tb_cdc_fifo --Mdir "$build_dir" -o tb_cdc_fifo
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$build_dir/tb_cdc_fifo" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "$fail_text" "$log_file"; then
  exit 1
fi
if ! grep -q "$pass_text" "$log_file"; then
  echo "simulation log has no result line"
  exit 1
fi
exit 0

// ==== tb/cdc_fifo_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo_assert (
  input wire logic                src_clk_i,
  input wire logic                src_rst_ni,
  input wire logic                src_clear_pending_o,
  input wire logic                src_ready_o,
  input wire logic                dst_clk_i,
  input wire logic                dst_rst_ni,
  input wire logic                dst_clear_pending_o,
  input wire logic                dst_valid_o,
  input wire logic                dst_ready_i,
  input wire cdc_fifo_pkg::data_t dst_data_o
);

  // a stalled output word must not change under the consumer
  data_hold_a: assert property (@(posedge dst_clk_i) disable iff (!dst_rst_ni)
    (dst_valid_o && !dst_ready_i) |=> $stable(dst_data_o))
    else $error("dst_data_o changed while the output was stalled");

  // the producer is shut out for the whole clear sequence
  src_isolated_a: assert property (@(posedge src_clk_i) disable iff (!src_rst_ni)
    src_clear_pending_o |-> !src_ready_o)
    else $error("src_ready_o high during a pending clear");

  // and the consumer sees nothing while its side is being cleared
  dst_isolated_a: assert property (@(posedge dst_clk_i) disable iff (!dst_rst_ni)
    dst_clear_pending_o |-> !dst_valid_o)
    else $error("dst_valid_o high during a pending clear");

endmodule

bind cdc_fifo_clearable cdc_fifo_assert u_assert (
  .src_clk_i           (src_clk_i),
  .src_rst_ni          (src_rst_ni),
  .src_clear_pending_o (src_clear_pending_o),
  .src_ready_o         (src_ready_o),
  .dst_clk_i           (dst_clk_i),
  .dst_rst_ni          (dst_rst_ni),
  .dst_clear_pending_o (dst_clear_pending_o),
  .dst_valid_o         (dst_valid_o),
  .dst_ready_i         (dst_ready_i),
  .dst_data_o          (dst_data_o)
);

`default_nettype wire

// ==== tb/tb_cdc_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cdc_fifo;

  localparam int LogDepth   = 3;
  localparam int SyncStages = 2;
  localparam int Depth      = 2 ** LogDepth;
  // upper bound for every wait loop, in cycles of the clock it waits on
  localparam int WaitLimit  = 1000;

  logic                src_clk_i;
  logic                src_rst_ni;
  logic                src_clear_i;
  logic                src_clear_pending_o;
  cdc_fifo_pkg::data_t src_data_i;
  logic                src_valid_i;
  logic                src_ready_o;
  logic                dst_clk_i;
  logic                dst_rst_ni;
  logic                dst_clear_i;
  logic                dst_clear_pending_o;
  cdc_fifo_pkg::data_t dst_data_o;
  logic                dst_valid_o;
  logic                dst_ready_i;

  // words accepted by the source side, in order, for the running test
  cdc_fifo_pkg::data_t exp_q[$];
  // every word handed out by the destination side since the start
  cdc_fifo_pkg::data_t got_q[$];
  logic [31:0]         rng_state;
  int                  errors;
  int                  checks;
  int                  tests_run;
  int                  tests_failed;

  cdc_fifo_clearable #(
    .LogDepth   (LogDepth),
    .SyncStages (SyncStages)
  ) u_dut (
    .src_clk_i           (src_clk_i),
    .src_rst_ni          (src_rst_ni),
    .src_clear_i         (src_clear_i),
    .src_clear_pending_o (src_clear_pending_o),
    .src_data_i          (src_data_i),
    .src_valid_i         (src_valid_i),
    .src_ready_o         (src_ready_o),
    .dst_clk_i           (dst_clk_i),
    .dst_rst_ni          (dst_rst_ni),
    .dst_clear_i         (dst_clear_i),
    .dst_clear_pending_o (dst_clear_pending_o),
    .dst_data_o          (dst_data_o),
    .dst_valid_o         (dst_valid_o),
    .dst_ready_i         (dst_ready_i)
  );

  initial begin
    dst_clk_i = 1'b0;
    forever #2 dst_clk_i = ~dst_clk_i;
  end

  // source runs slower, so both directions of the crossing get exercised
  initial begin
    src_clk_i = 1'b0;
    forever #3 src_clk_i = ~src_clk_i;
  end

  // the monitor records every completed output handshake
  always @(posedge dst_clk_i) begin
    if (dst_valid_o && dst_ready_i) begin
      got_q.push_back(dst_data_o);
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
    end
  endtask

  // offers one word and holds it until the source side takes it
  // must be entered right after a source clock edge
  task automatic send_word(input cdc_fifo_pkg::data_t w);
    int cycles;
    cycles = 0;
    src_valid_i <= 1'b1;
    src_data_i  <= w;
    do begin
      @(posedge src_clk_i);
      cycles++;
    end while (!src_ready_o && cycles < WaitLimit);
    if (src_ready_o) begin
      exp_q.push_back(w);
    end else begin
      errors++;
      $display("timeout after %0d src cycles, src_ready_o never accepted a word", cycles);
    end
  endtask

  task automatic wait_received(input int target);
    int cycles;
    cycles = 0;
    while (got_q.size() < target && cycles < WaitLimit) begin
      @(posedge dst_clk_i);
      cycles++;
    end
    if (got_q.size() < target) begin
      errors++;
      $display("timeout after %0d dst cycles, %0d of %0d words arrived",
               cycles, got_q.size(), target);
    end
  endtask

  // waits until the destination side presents a word at its output
  task automatic wait_output_valid();
    int cycles;
    cycles = 0;
    while (!dst_valid_o && cycles < WaitLimit) begin
      @(posedge dst_clk_i);
      cycles++;
    end
    if (!dst_valid_o) begin
      errors++;
      $display("timeout after %0d dst cycles, dst_valid_o never rose", cycles);
    end
  endtask

  task automatic compare_run(input int base, input int n);
    for (int i = 0; i < n; i++) begin
      check_value("dst_data_o", 32'(got_q[base + i]), 32'(exp_q[i]));
    end
  endtask

  // gives late words time to show up, then checks the total count
  task automatic check_count(input int base, input int n);
    repeat (20) @(posedge dst_clk_i);
    check_value("received word count", got_q.size() - base, n);
  endtask

  task automatic pulse_clear(input bit src_side);
    if (src_side) begin
      @(posedge src_clk_i);
      src_clear_i <= 1'b1;
      @(posedge src_clk_i);
      src_clear_i <= 1'b0;
    end else begin
      @(posedge dst_clk_i);
      dst_clear_i <= 1'b1;
      @(posedge dst_clk_i);
      dst_clear_i <= 1'b0;
    end
  endtask

  // each side's pending flag has to rise and then fall again,
  // sampled on the clock of its own side
  task automatic watch_pending(input bit src_side);
    int   cycles;
    bit   seen_high;
    logic level;
    cycles    = 0;
    seen_high = 1'b0;
    level     = 1'b0;
    while (!(seen_high && !level) && cycles < WaitLimit) begin
      if (src_side) begin
        @(posedge src_clk_i);
        level = src_clear_pending_o;
      end else begin
        @(posedge dst_clk_i);
        level = dst_clear_pending_o;
      end
      seen_high = seen_high || level;
      cycles++;
    end
    if (!(seen_high && !level)) begin
      errors++;
      $display("timeout, %s clear pending flag did not rise and fall (seen high %0d)",
               src_side ? "src" : "dst", seen_high);
    end
  endtask

  // after a clear nothing may come out even with the consumer ready
  task automatic expect_empty();
    @(posedge dst_clk_i);
    dst_ready_i <= 1'b1;
    for (int i = 0; i < 20; i++) begin
      @(posedge dst_clk_i);
      if (dst_valid_o) begin
        check_value("dst_valid_o", 32'(dst_valid_o), 32'd0);
        break;
      end
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s finished without errors", name);
    end else begin
      tests_failed++;
      $display("test %s finished with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic in_order_transfer();
    int err_before;
    int base;
    err_before = errors;
    base       = got_q.size();
    exp_q.delete();
    @(posedge dst_clk_i);
    dst_ready_i <= 1'b1;
    @(posedge src_clk_i);
    for (int i = 0; i < 50; i++) begin
      send_word(cdc_fifo_pkg::data_t'(next_random()));
    end
    src_valid_i <= 1'b0;
    wait_received(base + 50);
    check_count(base, 50);
    compare_run(base, 50);
    finish_test("in_order_transfer", err_before);
  endtask

  task automatic full_depth();
    int                  err_before;
    int                  base;
    int                  accepted;
    int                  low_run;
    int                  cycles;
    cdc_fifo_pkg::data_t word;
    err_before = errors;
    base       = got_q.size();
    accepted   = 0;
    low_run    = 0;
    cycles     = 0;
    exp_q.delete();
    @(posedge dst_clk_i);
    dst_ready_i <= 1'b0;
    @(posedge src_clk_i);
    word = cdc_fifo_pkg::data_t'(next_random());
    src_valid_i <= 1'b1;
    src_data_i  <= word;
    // keep offering until ready has stayed low long enough to be final
    while (low_run < 40 && cycles < WaitLimit) begin
      @(posedge src_clk_i);
      cycles++;
      if (src_ready_o) begin
        exp_q.push_back(word);
        accepted++;
        low_run = 0;
        word = cdc_fifo_pkg::data_t'(next_random());
        src_data_i <= word;
      end else begin
        low_run++;
      end
    end
    src_valid_i <= 1'b0;
    if (low_run < 40) begin
      errors++;
      $display("timeout, src_ready_o never stayed low with the consumer stalled");
    end
    check_value("accepted word count", accepted, Depth + 2);
    @(posedge dst_clk_i);
    dst_ready_i <= 1'b1;
    wait_received(base + accepted);
    check_count(base, accepted);
    compare_run(base, accepted);
    finish_test("full_depth", err_before);
  endtask

  task automatic back_pressure();
    int err_before;
    int base;
    err_before = errors;
    base       = got_q.size();
    exp_q.delete();
    @(posedge src_clk_i);
    fork
      begin
        logic [31:0] r;
        for (int i = 0; i < 200; i++) begin
          r = next_random();
          // roughly one idle cycle in four between words
          if (r[1:0] == 2'b00) begin
            src_valid_i <= 1'b0;
            @(posedge src_clk_i);
          end
          send_word(cdc_fifo_pkg::data_t'(next_random()));
        end
        src_valid_i <= 1'b0;
      end
      begin
        logic [31:0] r;
        int          cycles;
        cycles = 0;
        @(posedge dst_clk_i);
        while (got_q.size() < base + 200 && cycles < 4 * WaitLimit) begin
          r = next_random();
          dst_ready_i <= r[2] | r[3];
          @(posedge dst_clk_i);
          cycles++;
        end
        dst_ready_i <= 1'b1;
        if (got_q.size() < base + 200) begin
          errors++;
          $display("timeout, only %0d of 200 words arrived under back-pressure",
                   got_q.size() - base);
        end
      end
    join
    check_count(base, 200);
    compare_run(base, 200);
    finish_test("back_pressure", err_before);
  endtask

  task automatic source_clear();
    int err_before;
    int base;
    err_before = errors;
    base       = got_q.size();
    exp_q.delete();
    @(posedge dst_clk_i);
    dst_ready_i <= 1'b0;
    @(posedge src_clk_i);
    for (int i = 0; i < 6; i++) begin
      send_word(cdc_fifo_pkg::data_t'(next_random()));
    end
    src_valid_i <= 1'b0;
    // the clear then also has to drop the words already held in the spill
    wait_output_valid();
    pulse_clear(1'b1);
    fork
      watch_pending(1'b1);
      watch_pending(1'b0);
    join
    expect_empty();
    exp_q.delete();
    base = got_q.size();
    @(posedge src_clk_i);
    for (int i = 0; i < 4; i++) begin
      send_word(cdc_fifo_pkg::data_t'(next_random()));
    end
    src_valid_i <= 1'b0;
    wait_received(base + 4);
    check_count(base, 4);
    compare_run(base, 4);
    finish_test("source_clear", err_before);
  endtask

  task automatic destination_clear();
    int err_before;
    int base;
    int kept;
    err_before = errors;
    base       = got_q.size();
    exp_q.delete();
    @(posedge dst_clk_i);
    dst_ready_i <= 1'b1;
    @(posedge src_clk_i);
    for (int i = 0; i < 6; i++) begin
      send_word(cdc_fifo_pkg::data_t'(next_random()));
    end
    src_valid_i <= 1'b0;
    pulse_clear(1'b0);
    fork
      watch_pending(1'b1);
      watch_pending(1'b0);
    join
    // whatever got out before the clear must be the oldest words in order
    kept = got_q.size() - base;
    if (kept > 6) begin
      errors++;
      $display("%0d words delivered around the clear, only 6 were written", kept);
      kept = 6;
    end
    compare_run(base, kept);
    expect_empty();
    exp_q.delete();
    base = base + kept;
    @(posedge src_clk_i);
    for (int i = 0; i < 4; i++) begin
      send_word(cdc_fifo_pkg::data_t'(next_random()));
    end
    src_valid_i <= 1'b0;
    wait_received(base + 4);
    check_count(base, 4);
    compare_run(base, 4);
    finish_test("destination_clear", err_before);
  endtask

  initial begin
    errors       = 0;
    checks       = 0;
    tests_run    = 0;
    tests_failed = 0;
    rng_state    = 32'he79f_c724;
    src_rst_ni  <= 1'b0;
    dst_rst_ni  <= 1'b0;
    src_clear_i <= 1'b0;
    dst_clear_i <= 1'b0;
    src_valid_i <= 1'b0;
    src_data_i  <= '0;
    dst_ready_i <= 1'b0;
    // both sides always come out of reset together
    fork
      begin
        repeat (3) @(posedge src_clk_i);
        src_rst_ni <= 1'b1;
      end
      begin
        repeat (3) @(posedge dst_clk_i);
        dst_rst_ni <= 1'b1;
      end
    join
    @(posedge src_clk_i);
    check_value("src_ready_o", 32'(src_ready_o), 32'd1);
    check_value("src_clear_pending_o", 32'(src_clear_pending_o), 32'd0);
    @(posedge dst_clk_i);
    check_value("dst_valid_o", 32'(dst_valid_o), 32'd0);
    check_value("dst_clear_pending_o", 32'(dst_clear_pending_o), 32'd0);
    in_order_transfer();
    full_depth();
    back_pressure();
    source_clear();
    destination_clear();
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
